/* design/rv32i_config.svh */
`ifndef RV32I_CONFIG_SVH
`define RV32I_CONFIG_SVH

// data memory answers after this many request cycles (1 to 8)
`define DMEM_LATENCY 2

// address bits of the data memory word array
`define DMEM_WORDS_LOG2 6

`endif

/* design/rv32i_types.sv */
`default_nettype none

package rv32i_types;

    // load codes from the funct3 field
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } funct3_t;

    // store codes share encodings with the signed loads
    localparam funct3_t sb = lb;
    localparam funct3_t sh = lh;
    localparam funct3_t sw = lw;

    // retirement monitor record, trimmed to the memory slice
    typedef struct packed {
        logic        monitor_valid;
        logic [31:0] monitor_order;
        logic [31:0] monitor_rd_wdata;
        logic [31:0] monitor_mem_addr;
        logic [3:0]  monitor_mem_rmask;
        logic [3:0]  monitor_mem_wmask;
        logic [31:0] monitor_mem_wdata;
    } rvfi_t;

    typedef struct packed {
        logic        mem_read;
        logic        mem_write;
        funct3_t     funct3;
        logic [31:0] alu_result;
        logic [31:0] rs2_v;      // store source
        logic [4:0]  rd_s;
        logic        regf_we;
        rvfi_t       rvfi;
    } ex_mem_reg_t;

    typedef struct packed {
        logic [31:0] rd_v;       // alu result passed through
        logic [31:0] read_data;  // extended load result
        logic [4:0]  rd_s;
        logic        regf_we;
        logic        mem_read;
        rvfi_t       rvfi;
    } mem_wb_reg_t;

endpackage

`default_nettype wire

/* design/dmem_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dmem_if;

    logic [31:0] addr;   // word aligned
    logic [3:0]  rmask;
    logic [3:0]  wmask;
    logic [31:0] wdata;
    logic [31:0] rdata;  // valid only while resp is high
    logic        resp;   // one cycle pulse

    // requester side
    modport stage (
        output addr, rmask, wmask, wdata,
        input  rdata, resp
    );

    // memory side
    modport mem (
        input  addr, rmask, wmask, wdata,
        output rdata, resp
    );

endinterface

`default_nettype wire

/* design/pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_reg
#(
    parameter type payload_t = logic [31:0]
)
(
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // all-zero record carries monitor_valid low, so it is a bubble
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            q <= '0;
        end
        else if (!stall)
        begin
            q <= d;
        end
        // stall holds the current record
    end

endmodule

`default_nettype wire

/* design/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import rv32i_types::*;
(
    input  ex_mem_reg_t  ex_mem_reg,
    dmem_if.stage        dmem,
    output logic         stall,
    output mem_wb_reg_t  mem_wb_reg_next,
    output logic         wb_flush
);

    logic        access_valid;
    logic        load_valid;
    logic        store_valid;
    logic [1:0]  offset;
    logic [31:0] word_addr;
    logic [3:0]  rmask_calc;
    logic [3:0]  wmask_calc;
    logic [31:0] wdata_calc;
    logic [7:0]  load_byte;
    logic [15:0] load_half;
    logic [31:0] load_data;

    assign load_valid   = ex_mem_reg.rvfi.monitor_valid && ex_mem_reg.mem_read;
    assign store_valid  = ex_mem_reg.rvfi.monitor_valid && ex_mem_reg.mem_write;
    assign access_valid = load_valid || store_valid;

    assign offset    = ex_mem_reg.alu_result[1:0];
    assign word_addr = {ex_mem_reg.alu_result[31:2], 2'b00};

    // lane masks and lane-placed store data
    always_comb
    begin
        unique case (ex_mem_reg.funct3)
            lb, lbu: rmask_calc = 4'b0001 << offset;
            lh, lhu: rmask_calc = 4'b0011 << {offset[1], 1'b0};
            lw:      rmask_calc = 4'b1111;
            default: rmask_calc = 4'b0000;
        endcase

        wdata_calc = '0;
        unique case (ex_mem_reg.funct3)
            sb:
            begin
                wmask_calc = 4'b0001 << offset;
                wdata_calc[{offset, 3'b000} +: 8] = ex_mem_reg.rs2_v[7:0];
            end
            sh:
            begin
                wmask_calc = 4'b0011 << {offset[1], 1'b0};
                wdata_calc[{offset[1], 4'b0000} +: 16] = ex_mem_reg.rs2_v[15:0];
            end
            sw:
            begin
                wmask_calc = 4'b1111;
                wdata_calc = ex_mem_reg.rs2_v;
            end
            default: wmask_calc = 4'b0000;
        endcase
    end

    // request level held until resp, stage holds ex_mem meanwhile
    assign dmem.addr  = access_valid ? word_addr : '0;
    assign dmem.rmask = load_valid  ? rmask_calc : '0;
    assign dmem.wmask = store_valid ? wmask_calc : '0;
    assign dmem.wdata = store_valid ? wdata_calc : '0;

    assign stall    = access_valid && !dmem.resp;
    assign wb_flush = stall;  // keeps a waiting access out of writeback

    assign load_byte = dmem.rdata[{offset, 3'b000} +: 8];
    assign load_half = dmem.rdata[{offset[1], 4'b0000} +: 16];

    always_comb
    begin
        unique case (ex_mem_reg.funct3)
            lb:      load_data = {{24{load_byte[7]}}, load_byte};
            lbu:     load_data = {24'b0, load_byte};
            lh:      load_data = {{16{load_half[15]}}, load_half};
            lhu:     load_data = {16'b0, load_half};
            lw:      load_data = dmem.rdata;
            default: load_data = '0;
        endcase
    end

    always_comb
    begin
        mem_wb_reg_next.rd_v      = ex_mem_reg.alu_result;
        mem_wb_reg_next.read_data = load_data;
        mem_wb_reg_next.rd_s      = ex_mem_reg.rd_s;
        mem_wb_reg_next.regf_we   = ex_mem_reg.regf_we;
        mem_wb_reg_next.mem_read  = ex_mem_reg.mem_read;

        mem_wb_reg_next.rvfi.monitor_valid = ex_mem_reg.rvfi.monitor_valid;
        mem_wb_reg_next.rvfi.monitor_order = ex_mem_reg.rvfi.monitor_order;
        // loads retire the extended memory value instead of the address
        mem_wb_reg_next.rvfi.monitor_rd_wdata = ex_mem_reg.mem_read ? load_data
                                                                    : ex_mem_reg.rvfi.monitor_rd_wdata;
        mem_wb_reg_next.rvfi.monitor_mem_addr  = access_valid ? word_addr : '0;
        mem_wb_reg_next.rvfi.monitor_mem_rmask = load_valid  ? rmask_calc : '0;
        mem_wb_reg_next.rvfi.monitor_mem_wmask = store_valid ? wmask_calc : '0;
        mem_wb_reg_next.rvfi.monitor_mem_wdata = store_valid ? wdata_calc : '0;
    end

endmodule

`default_nettype wire

/* design/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_config.svh"

module data_memory
(
    input  logic clk,
    input  logic rst,
    dmem_if.mem  dmem
);

    localparam int DEPTH = 2 ** `DMEM_WORDS_LOG2;
    localparam int CNT_W = 4;  // enough for latencies up to 8
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`DMEM_LATENCY - 1);

    logic [31:0]                 mem_array [DEPTH];
    logic [CNT_W-1:0]            req_cnt;
    logic                        req;
    logic [`DMEM_WORDS_LOG2-1:0] word_idx;

    assign req      = (|dmem.rmask) || (|dmem.wmask);
    assign word_idx = dmem.addr[`DMEM_WORDS_LOG2+1:2];  // wraps modulo depth

    // answer in the last counted request cycle
    assign dmem.resp  = req && (req_cnt == LAST_CNT);
    assign dmem.rdata = dmem.resp ? mem_array[word_idx] : '0;

    // request cycle counter
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            req_cnt <= '0;
        end
        else if (!req || dmem.resp)
        begin
            req_cnt <= '0;  // restart for the next request
        end
        else
        begin
            req_cnt <= req_cnt + 1'b1;
        end
    end

    // byte lanes are written at the edge closing the resp cycle
    always_ff @(posedge clk)
    begin
        if (dmem.resp)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (dmem.wmask[i])
                    mem_array[word_idx][8*i +: 8] <= dmem.wdata[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* design/mem_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top
    import rv32i_types::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic        in_mem_read,
    input  logic        in_mem_write,
    input  logic [2:0]  in_funct3,
    input  logic [31:0] in_alu_result,
    input  logic [31:0] in_rs2_v,
    input  logic [4:0]  in_rd_s,
    input  logic        in_regf_we,
    input  logic [31:0] in_order,
    output logic        stall,
    output logic        wb_valid,
    output logic [31:0] wb_order,
    output logic [4:0]  wb_rd_s,
    output logic        wb_regf_we,
    output logic [31:0] wb_rd_wdata,
    output logic [31:0] wb_mem_addr,
    output logic [3:0]  wb_mem_rmask,
    output logic [3:0]  wb_mem_wmask,
    output logic [31:0] wb_mem_wdata
);

    ex_mem_reg_t ex_mem_d;
    ex_mem_reg_t ex_mem_q;
    mem_wb_reg_t mem_wb_d;
    mem_wb_reg_t mem_wb_q;
    logic        wb_flush;

    dmem_if dmem_bus ();

    // execute result as it would leave the execute stage
    assign ex_mem_d.mem_read   = in_mem_read;
    assign ex_mem_d.mem_write  = in_mem_write;
    assign ex_mem_d.funct3     = funct3_t'(in_funct3);
    assign ex_mem_d.alu_result = in_alu_result;
    assign ex_mem_d.rs2_v      = in_rs2_v;
    assign ex_mem_d.rd_s       = in_rd_s;
    assign ex_mem_d.regf_we    = in_regf_we;
    assign ex_mem_d.rvfi       = '{monitor_valid: in_valid, monitor_order: in_order,
                                   monitor_rd_wdata: in_alu_result, default: '0};

    pipe_reg #(.payload_t(ex_mem_reg_t)) ex_mem_i (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .flush (1'b0),
        .d     (ex_mem_d),
        .q     (ex_mem_q)
    );

    mem_stage mem_stage_i (
        .ex_mem_reg      (ex_mem_q),
        .dmem            (dmem_bus.stage),
        .stall           (stall),
        .mem_wb_reg_next (mem_wb_d),
        .wb_flush        (wb_flush)
    );

    data_memory dmem_i (
        .clk  (clk),
        .rst  (rst),
        .dmem (dmem_bus.mem)
    );

    // never held, bubbles enter while the access waits
    pipe_reg #(.payload_t(mem_wb_reg_t)) mem_wb_i (
        .clk   (clk),
        .rst   (rst),
        .stall (1'b0),
        .flush (wb_flush),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

    assign wb_valid     = mem_wb_q.rvfi.monitor_valid;
    assign wb_order     = mem_wb_q.rvfi.monitor_order;
    assign wb_rd_s      = mem_wb_q.rd_s;
    assign wb_regf_we   = mem_wb_q.regf_we;
    assign wb_rd_wdata  = mem_wb_q.rvfi.monitor_rd_wdata;
    assign wb_mem_addr  = mem_wb_q.rvfi.monitor_mem_addr;
    assign wb_mem_rmask = mem_wb_q.rvfi.monitor_mem_rmask;
    assign wb_mem_wmask = mem_wb_q.rvfi.monitor_mem_wmask;
    assign wb_mem_wdata = mem_wb_q.rvfi.monitor_mem_wdata;

endmodule

`default_nettype wire

/* dv/mem_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_config.svh"

module mem_checker
    import rv32i_types::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic        in_mem_read,
    input  logic        in_mem_write,
    input  logic [2:0]  in_funct3,
    input  logic [31:0] in_alu_result,
    input  logic [31:0] in_rs2_v,
    input  logic [4:0]  in_rd_s,
    input  logic        in_regf_we,
    input  logic [31:0] in_order,
    input  logic        stall,
    input  logic        wb_valid,
    input  logic [31:0] wb_order,
    input  logic [4:0]  wb_rd_s,
    input  logic        wb_regf_we,
    input  logic [31:0] wb_rd_wdata,
    input  logic [31:0] wb_mem_addr,
    input  logic [3:0]  wb_mem_rmask,
    input  logic [3:0]  wb_mem_wmask,
    input  logic [31:0] wb_mem_wdata,
    output int          mismatch_count,
    output int          other_count,
    output int          pending_ops
);

    typedef struct packed {
        logic        mem_read;
        logic        mem_write;
        logic [2:0]  funct3;
        logic [31:0] alu;
        logic [31:0] rs2;
        logic [31:0] order;
        logic [4:0]  rd_s;
        logic        regf_we;
        logic [31:0] accept_cycle;
    } op_t;

    typedef struct packed {
        logic [31:0] rd_wdata;
        logic [31:0] addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } wb_exp_t;

    logic [31:0] shadow [2 ** `DMEM_WORDS_LOG2];
    op_t         ops_q [$];
    logic [31:0] cycle_cnt = 32'd0;
    logic        rst_prev = 1'b0;

    initial
    begin
        mismatch_count = 0;
        other_count = 0;
        pending_ops = 0;
    end

    // expected writeback for one operation given the current memory word
    function automatic wb_exp_t ref_writeback(op_t op, logic [31:0] mem_word);
        wb_exp_t     e;
        logic [1:0]  off;
        logic [31:0] lane_word;
        logic [31:0] half_word;

        off = op.alu[1:0];
        lane_word = mem_word >> {off, 3'b000};
        half_word = mem_word >> {off[1], 4'b0000};
        e = '0;
        e.rd_wdata = op.alu;
        if (op.mem_read || op.mem_write)
            e.addr = {op.alu[31:2], 2'b00};
        if (op.mem_read)
        begin
            case (op.funct3)
                lb:      e.rd_wdata = {{24{lane_word[7]}}, lane_word[7:0]};
                lbu:     e.rd_wdata = {24'b0, lane_word[7:0]};
                lh:      e.rd_wdata = {{16{half_word[15]}}, half_word[15:0]};
                lhu:     e.rd_wdata = {16'b0, half_word[15:0]};
                default: e.rd_wdata = mem_word;
            endcase
            case (op.funct3)
                lb, lbu: e.rmask = 4'b0001 << off;
                lh, lhu: e.rmask = off[1] ? 4'b1100 : 4'b0011;
                default: e.rmask = 4'b1111;
            endcase
        end
        if (op.mem_write)
        begin
            case (op.funct3)
                sb:
                begin
                    e.wmask = 4'b0001 << off;
                    e.wdata = {24'b0, op.rs2[7:0]} << {off, 3'b000};
                end
                sh:
                begin
                    e.wmask = off[1] ? 4'b1100 : 4'b0011;
                    e.wdata = {16'b0, op.rs2[15:0]} << {off[1], 4'b0000};
                end
                default:
                begin
                    e.wmask = 4'b1111;
                    e.wdata = op.rs2;
                end
            endcase
        end
        return e;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp)
        begin
            $display("CHECK FAILED at %0t: %s expected %h, actual %h", $time, name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic compare_writeback();
        op_t                         op;
        wb_exp_t                     e;
        logic [`DMEM_WORDS_LOG2-1:0] idx;

        if (ops_q.size() == 0)
        begin
            $display("writeback of order %0d at %0t with no operation outstanding",
                     wb_order, $time);
            other_count++;
            return;
        end
        op = ops_q.pop_front();
        idx = op.alu[`DMEM_WORDS_LOG2+1:2];
        e = ref_writeback(op, shadow[idx]);
        check_field("wb_order", op.order, wb_order);
        check_field("wb_rd_s", 32'(op.rd_s), 32'(wb_rd_s));
        check_field("wb_regf_we", 32'(op.regf_we), 32'(wb_regf_we));
        check_field("wb_rd_wdata", e.rd_wdata, wb_rd_wdata);
        check_field("wb_mem_addr", e.addr, wb_mem_addr);
        check_field("wb_mem_rmask", 32'(e.rmask), 32'(wb_mem_rmask));
        check_field("wb_mem_wmask", 32'(e.wmask), 32'(wb_mem_wmask));
        check_field("wb_mem_wdata", e.wdata, wb_mem_wdata);
        if (!op.mem_read && !op.mem_write && (cycle_cnt - op.accept_cycle) != 32'd2)
        begin
            $display("non-memory operation %0d wrote back %0d cycles after acceptance, not 2",
                     op.order, cycle_cnt - op.accept_cycle);
            other_count++;
        end
        for (int i = 0; i < 4; i++)
        begin
            if (e.wmask[i])
                shadow[idx][8*i +: 8] = e.wdata[8*i +: 8];
        end
    endtask

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (rst_prev)  // registers hold known values after the first reset edge
        begin
            check_field("stall", 32'd0, 32'(stall));
            check_field("wb_valid", 32'd0, 32'(wb_valid));
        end
        if (!rst)
        begin
            if (wb_valid === 1'b1)
                compare_writeback();
            if (in_valid === 1'b1 && stall === 1'b0)
                ops_q.push_back('{in_mem_read, in_mem_write, in_funct3, in_alu_result,
                                  in_rs2_v, in_order, in_rd_s, in_regf_we, cycle_cnt});
        end
        rst_prev = rst;
        pending_ops = ops_q.size();
    end

endmodule

`default_nettype wire

/* dv/tb_mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_config.svh"

module tb_mem_subsystem
    import rv32i_types::*;
;

    localparam int TIMEOUT_CYCLES = 216 * (`DMEM_LATENCY + 2) + 50;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_mem_read;
    logic        in_mem_write;
    logic [2:0]  in_funct3;
    logic [31:0] in_alu_result;
    logic [31:0] in_rs2_v;
    logic [4:0]  in_rd_s;
    logic        in_regf_we;
    logic [31:0] in_order;
    logic        stall;
    logic        wb_valid;
    logic [31:0] wb_order;
    logic [4:0]  wb_rd_s;
    logic        wb_regf_we;
    logic [31:0] wb_rd_wdata;
    logic [31:0] wb_mem_addr;
    logic [3:0]  wb_mem_rmask;
    logic [3:0]  wb_mem_wmask;
    logic [31:0] wb_mem_wdata;

    int          mismatch_count;
    int          other_count;
    int          pending_ops;
    int          seed = 32'h9e8a74cc;
    int          cycle_count = 0;
    logic [31:0] next_order = 32'd0;

    mem_subsystem_top dut_i (.*);

    mem_checker chk_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run still busy after %0d cycles", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    // call on a falling edge and it returns on the falling edge after acceptance
    task automatic issue_op(input logic valid, input logic rd, input logic wr,
                            input logic [2:0] f3, input logic [31:0] alu,
                            input logic [31:0] rs2, input logic [4:0] rd_s,
                            input logic we);
        in_valid      = valid;
        in_mem_read   = rd;
        in_mem_write  = wr;
        in_funct3     = f3;
        in_alu_result = alu;
        in_rs2_v      = rs2;
        in_rd_s       = rd_s;
        in_regf_we    = we;
        in_order      = next_order;
        if (valid)
            next_order++;
        while (stall)
            @(negedge clk);  // hold inputs while ex_mem is busy
        @(negedge clk);
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] byte_addr;
        logic [31:0] half_addr;
        logic [31:0] word_addr;
        int          sel;

        rst = 1'b1;
        // reset must keep this valid store out of ex_mem
        in_valid = 1'b1;
        in_mem_read = 1'b0;
        in_mem_write = 1'b1;
        in_funct3 = sw;
        in_alu_result = 32'd0;
        in_rs2_v = 32'hffff_ffff;
        in_rd_s = 5'd0;
        in_regf_we = 1'b0;
        in_order = 32'd0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // prefill the first 16 words
        for (int i = 0; i < 16; i++)
        begin
            r = $random(seed);
            issue_op(1'b1, 1'b0, 1'b1, sw, 32'(i * 4), r, 5'd0, 1'b0);
        end

        for (int n = 0; n < 200; n++)
        begin
            r = $random(seed);
            r2 = $random(seed);
            sel = int'(r2 % 32'd10);
            byte_addr = {26'b0, r2[9:4]};
            half_addr = {26'b0, r2[9:5], 1'b0};
            word_addr = {26'b0, r2[9:6], 2'b00};
            case (sel)
                0: issue_op(1'b1, 1'b1, 1'b0, lb,  byte_addr, r, r2[14:10], 1'b1);
                1: issue_op(1'b1, 1'b1, 1'b0, lh,  half_addr, r, r2[14:10], 1'b1);
                2: issue_op(1'b1, 1'b1, 1'b0, lw,  word_addr, r, r2[14:10], 1'b1);
                3: issue_op(1'b1, 1'b1, 1'b0, lbu, byte_addr, r, r2[14:10], 1'b1);
                4: issue_op(1'b1, 1'b1, 1'b0, lhu, half_addr, r, r2[14:10], 1'b1);
                5: issue_op(1'b1, 1'b0, 1'b1, sb,  byte_addr, r, r2[14:10], 1'b0);
                6: issue_op(1'b1, 1'b0, 1'b1, sh,  half_addr, r, r2[14:10], 1'b0);
                7: issue_op(1'b1, 1'b0, 1'b1, sw,  word_addr, r, r2[14:10], 1'b0);
                8: issue_op(1'b1, 1'b0, 1'b0, r2[17:15], r, r2, r2[14:10], 1'b1);
                // a bubble that looks like a store must not touch memory
                default: issue_op(1'b0, 1'b0, 1'b1, sw, word_addr, r, r2[14:10], 1'b0);
            endcase
        end

        repeat (2)
            issue_op(1'b0, 1'b0, 1'b0, 3'b000, 32'd0, 32'd0, 5'd0, 1'b0);

        while (pending_ops != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);  // room for a duplicate writeback to show

        $display("errors: %0d value mismatches, %0d other failures",
                 mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/rv32i_types.sv
design/dmem_if.sv
design/pipe_reg.sv
design/mem_stage.sv
design/data_memory.sv
design/mem_subsystem_top.sv
dv/mem_checker.sv
dv/tb_mem_subsystem.sv

/* Makefile */
TOP = tb_mem_subsystem

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

obj_dir/V$(TOP): sources.f design/*.sv design/*.svh dv/*.sv
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "test failed" sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
